/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_compute_tile
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG) || ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rtl/compute_tile.sv */
module compute_tile #(
   parameter int unsigned tile_id = 0            // Own NoC address
) (
   input  logic                clk,
   input  logic                reset_i,

   // Core side bus port
   input  tile_pkg::wb_req_t   core_req_i,
   output tile_pkg::wb_rsp_t   core_rsp_o,

   // NoC ports
   input  tile_pkg::flit_t     noc_in_flit_i,
   input  logic                noc_in_valid_i,
   output logic                noc_in_ready_o,
   output tile_pkg::flit_t     noc_out_flit_o,
   output logic                noc_out_valid_o,
   input  logic                noc_out_ready_i,

   output logic                irq_o             // Rx flits pending
);

   tile_pkg::wb_req_t ram_req, na_req, rom_req;  // Per slave requests
   tile_pkg::wb_rsp_t ram_rsp, na_rsp, rom_rsp;

   tile_bus_decode u_decode (
      .clk        (clk),
      .reset_i    (reset_i),
      .core_req_i (core_req_i),
      .core_rsp_o (core_rsp_o),
      .ram_req_o  (ram_req),
      .na_req_o   (na_req),
      .rom_req_o  (rom_req),
      .ram_rsp_i  (ram_rsp),
      .na_rsp_i   (na_rsp),
      .rom_rsp_i  (rom_rsp)
   );

   tile_ram u_ram (
      .clk     (clk),
      .reset_i (reset_i),
      .req_i   (ram_req),
      .rsp_o   (ram_rsp)
   );

   tile_bootrom u_bootrom (
      .clk     (clk),
      .reset_i (reset_i),
      .req_i   (rom_req),
      .rsp_o   (rom_rsp)
   );

   noc_adapter #(.tile_id(tile_id)) u_na (
      .clk             (clk),
      .reset_i         (reset_i),
      .req_i           (na_req),
      .rsp_o           (na_rsp),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .irq_o           (irq_o)
   );

endmodule

/* rtl/noc_adapter.sv */
module noc_adapter #(
   parameter int unsigned tile_id = 0            // Inserted as header src
) (
   input  logic              clk,
   input  logic              reset_i,

   input  tile_pkg::wb_req_t req_i,              // Register access
   output tile_pkg::wb_rsp_t rsp_o,

   input  tile_pkg::flit_t   noc_in_flit_i,
   input  logic              noc_in_valid_i,
   output logic              noc_in_ready_o,
   output tile_pkg::flit_t   noc_out_flit_o,
   output logic              noc_out_valid_o,
   input  logic              noc_out_ready_i,

   output logic              irq_o               // Level, rx not empty
);

   logic [tile_pkg::BUS_AW-1:0] reg_off;         // Register offset
   logic                        acc;             // Access seen this cycle
   logic                        ack_q;
   logic                        is_tx;           // Any transmit offset
   logic                        tx_free;         // Out path can take a flit
   logic                        tx_load;         // Transmit write accepted
   logic                        tx_pend_q;       // Flit staged for out register
   tile_pkg::flit_t             tx_flit;
   tile_pkg::flit_t             tx_flit_q;
   tile_pkg::flit_t             out_flit_q;
   logic                        out_valid_q;

   tile_pkg::flit_t             rx_mem [tile_pkg::RX_DEPTH];
   logic [tile_pkg::RX_PW-1:0]  wr_ptr_q;
   logic [tile_pkg::RX_PW-1:0]  rd_ptr_q;
   logic [tile_pkg::RX_CW-1:0]  rx_count_q;
   logic                        rx_empty;
   logic                        rx_push;
   logic                        rx_pop;

   logic [tile_pkg::BUS_DW-1:0] status_word;
   logic [tile_pkg::BUS_DW-1:0] rd_word;
   logic [tile_pkg::BUS_DW-1:0] rd_dat_q;

   assign reg_off = req_i.adr & ~tile_pkg::REGION_MASK;
   assign acc     = req_i.cyc & req_i.stb & ~ack_q;
   assign is_tx   = (reg_off == tile_pkg::NA_TX_HEADER) |
                    (reg_off == tile_pkg::NA_TX_PAYLOAD) |
                    (reg_off == tile_pkg::NA_TX_LAST);

   // Free when nothing staged and out register empty or draining now
   assign tx_free = ~tx_pend_q & (~out_valid_q | noc_out_ready_i);
   assign tx_load = acc & req_i.we & is_tx & tx_free;

   always_comb begin
      tx_flit.data.raw = req_i.dat;              // Payload as written
      case (reg_off)
         tile_pkg::NA_TX_HEADER: begin
            tx_flit.ftype        = tile_pkg::HEADER;
            tx_flit.data.hdr.src = tile_pkg::NODE_W'(tile_id); // Own address
         end
         tile_pkg::NA_TX_LAST: tx_flit.ftype = tile_pkg::LAST;
         default:              tx_flit.ftype = tile_pkg::PAYLOAD;
      endcase
   end

   assign rx_empty       = (rx_count_q == '0);
   assign noc_in_ready_o = (rx_count_q != tile_pkg::RX_CW'(tile_pkg::RX_DEPTH));
   assign rx_push        = noc_in_valid_i & noc_in_ready_o;
   assign rx_pop         = acc & ~req_i.we & (reg_off == tile_pkg::NA_RX_DATA) & ~rx_empty;

   always_comb begin
      status_word                        = '0;
      status_word[tile_pkg::RX_CW-1:0]   = rx_count_q;   // Fill level
      if (!rx_empty) status_word[17:16] = rx_mem[rd_ptr_q].ftype; // Head type
   end

   always_comb begin
      case (reg_off)
         tile_pkg::NA_RX_DATA:   rd_word = rx_empty ? '0 : rx_mem[rd_ptr_q].data.raw;
         tile_pkg::NA_RX_STATUS: rd_word = status_word;
         default:                rd_word = '0;   // Tx offsets read zero
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q       <= 1'b0;
         tx_pend_q   <= 1'b0;
         out_valid_q <= 1'b0;
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         rx_count_q  <= '0;
      end else begin
         ack_q     <= acc & ~(req_i.we & is_tx & ~tx_free); // Hold ack on back-pressure
         tx_pend_q <= tx_load;                   // One cycle stage after ack
         if (tx_pend_q) begin
            out_valid_q <= 1'b1;
         end else if (out_valid_q && noc_out_ready_i) begin
            out_valid_q <= 1'b0;                 // Flit taken by router
         end
         if (rx_push) wr_ptr_q <= wr_ptr_q + 1'b1; // Wraps at depth
         if (rx_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
         rx_count_q <= rx_count_q + tile_pkg::RX_CW'(rx_push)
                                  - tile_pkg::RX_CW'(rx_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (tx_load)   tx_flit_q  <= tx_flit;
      if (tx_pend_q) out_flit_q <= tx_flit_q;    // Out register is empty here
      if (rx_push)   rx_mem[wr_ptr_q] <= noc_in_flit_i;
      if (acc)       rd_dat_q <= rd_word;
   end

   assign rsp_o           = '{dat: rd_dat_q, ack: ack_q, err: 1'b0};
   assign noc_out_flit_o  = out_flit_q;
   assign noc_out_valid_o = out_valid_q;
   assign irq_o           = ~rx_empty;

endmodule

/* rtl/tile_bootrom.sv */
module tile_bootrom (
   input  logic              clk,
   input  logic              reset_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   logic [tile_pkg::BUS_AW-1:0]            rom_off; // Offset inside ROM region
   logic [$clog2(tile_pkg::BOOTROM_WORDS)-1:0] rom_idx;
   logic                                   in_table;
   logic                                   acc;
   logic                                   ack_q;
   logic                                   err_q;
   logic [tile_pkg::BUS_DW-1:0]            dat_q;

   assign rom_off  = req_i.adr & ~tile_pkg::REGION_MASK;
   assign rom_idx  = rom_off[$clog2(tile_pkg::BOOTROM_WORDS)+1:2];
   assign in_table = rom_off[tile_pkg::BUS_AW-1:2] <
                     (tile_pkg::BUS_AW-2)'(tile_pkg::BOOTROM_WORDS);
   assign acc      = req_i.cyc & req_i.stb & ~ack_q & ~err_q;

   always_ff @(posedge clk) begin
      if (acc) dat_q <= in_table ? tile_pkg::BOOTROM_INIT[rom_idx] : '0; // Zero past table
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= acc & ~req_i.we;
         err_q <= acc & req_i.we;                // Read only, writes rejected
      end
   end

   assign rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};

endmodule

/* rtl/tile_bus_decode.sv */
module tile_bus_decode (
   input  logic              clk,
   input  logic              reset_i,

   input  tile_pkg::wb_req_t core_req_i,         // From the single master
   output tile_pkg::wb_rsp_t core_rsp_o,

   output tile_pkg::wb_req_t ram_req_o,
   output tile_pkg::wb_req_t na_req_o,
   output tile_pkg::wb_req_t rom_req_o,
   input  tile_pkg::wb_rsp_t ram_rsp_i,
   input  tile_pkg::wb_rsp_t na_rsp_i,
   input  tile_pkg::wb_rsp_t rom_rsp_i
);

   logic [tile_pkg::BUS_AW-1:0] region;          // Masked top nibble
   logic                        req_act;         // Master strobing
   logic                        err_q;           // Unmapped access error pulse
   tile_pkg::slave_e            sel_d;           // Target of current request
   tile_pkg::slave_e            sel_q;           // Target owning the response

   assign region  = core_req_i.adr & tile_pkg::REGION_MASK;
   assign req_act = core_req_i.cyc & core_req_i.stb;

   always_comb begin
      if (region == tile_pkg::RAM_BASE) begin
         sel_d = tile_pkg::SL_RAM;
      end else if (region == tile_pkg::NA_BASE) begin
         sel_d = tile_pkg::SL_NA;
      end else if (region == tile_pkg::ROM_BASE) begin
         sel_d = tile_pkg::SL_ROM;
      end else begin
         sel_d = tile_pkg::SL_NONE;              // Hole in the map
      end
   end

   // Same request everywhere, only the chosen slave sees stb
   always_comb begin
      ram_req_o     = core_req_i;
      na_req_o      = core_req_i;
      rom_req_o     = core_req_i;
      ram_req_o.stb = core_req_i.stb & (sel_d == tile_pkg::SL_RAM);
      na_req_o.stb  = core_req_i.stb & (sel_d == tile_pkg::SL_NA);
      rom_req_o.stb = core_req_i.stb & (sel_d == tile_pkg::SL_ROM);
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         sel_q <= tile_pkg::SL_NONE;
         err_q <= 1'b0;
      end else begin
         if (req_act) sel_q <= sel_d;            // Held while master waits
         err_q <= req_act & (sel_d == tile_pkg::SL_NONE) & ~err_q; // Single cycle err
      end
   end

   always_comb begin
      case (sel_q)
         tile_pkg::SL_RAM: core_rsp_o = ram_rsp_i;
         tile_pkg::SL_NA:  core_rsp_o = na_rsp_i;
         tile_pkg::SL_ROM: core_rsp_o = rom_rsp_i;
         default:          core_rsp_o = '{dat: '0, ack: 1'b0, err: err_q};
      endcase
   end

endmodule

/* rtl/tile_pkg.sv */
package tile_pkg;

   localparam int BUS_AW = 32;                   // Bus address width
   localparam int BUS_DW = 32;                   // Bus data width
   localparam int BUS_SW = BUS_DW / 8;           // One select per byte

   typedef struct packed {
      logic [BUS_AW-1:0] adr;
      logic [BUS_DW-1:0] dat;                    // Write data
      logic [BUS_SW-1:0] sel;                    // Byte lanes
      logic              we;
      logic              cyc;
      logic              stb;
   } wb_req_t;

   typedef struct packed {
      logic [BUS_DW-1:0] dat;                    // Read data
      logic              ack;
      logic              err;
   } wb_rsp_t;

   localparam int MEM_SIZE = 4096;               // RAM bytes
   localparam int MEM_AW   = $clog2(MEM_SIZE);   // RAM byte address bits

   localparam logic [BUS_AW-1:0] RAM_BASE    = 32'h0000_0000;
   localparam logic [BUS_AW-1:0] NA_BASE     = 32'hE000_0000;
   localparam logic [BUS_AW-1:0] ROM_BASE    = 32'hF000_0000;
   localparam logic [BUS_AW-1:0] REGION_MASK = 32'hF000_0000; // Top nibble picks the slave

   localparam int BOOTROM_WORDS = 8;
   // Startup stub, sets the stack pointer and jumps into RAM
   localparam logic [BUS_DW-1:0] BOOTROM_INIT [BOOTROM_WORDS] = '{
      32'h1820_0000,                             // l.movhi r1,0
      32'hA821_1000,                             // l.ori   r1,r1,0x1000
      32'h1860_0000,                             // l.movhi r3,0
      32'hA863_0100,                             // l.ori   r3,r3,0x100
      32'h4400_1800,                             // l.jr    r3
      32'h1500_0000,                             // Delay slot
      32'h1500_0000,
      32'h1500_0000
   };

   // Same encoding as the NoC routers
   typedef enum logic [1:0] {
      PAYLOAD = 2'b00,
      HEADER  = 2'b01,
      LAST    = 2'b10,
      SINGLE  = 2'b11
   } flit_type_e;

   localparam int FLIT_DW  = 32;
   localparam int NODE_W   = 5;                  // Tile address bits
   localparam int PCLASS_W = 3;

   typedef struct packed {
      logic [NODE_W-1:0]                 dest;   // Routing target, top bits
      logic [NODE_W-1:0]                 src;
      logic [PCLASS_W-1:0]               pclass; // Packet class
      logic [FLIT_DW-2*NODE_W-PCLASS_W-1:0] rest;
   } flit_header_t;

   typedef union packed {
      flit_header_t       hdr;                   // Header view
      logic [FLIT_DW-1:0] raw;                   // Payload view
   } flit_data_u;

   typedef struct packed {
      flit_type_e ftype;
      flit_data_u data;
   } flit_t;

   // Adapter register offsets within NA_BASE region
   localparam logic [BUS_AW-1:0] NA_TX_HEADER  = 32'h00;
   localparam logic [BUS_AW-1:0] NA_TX_PAYLOAD = 32'h04;
   localparam logic [BUS_AW-1:0] NA_TX_LAST    = 32'h08;
   localparam logic [BUS_AW-1:0] NA_RX_DATA    = 32'h0C;
   localparam logic [BUS_AW-1:0] NA_RX_STATUS  = 32'h10;

   localparam int RX_DEPTH = 4;                  // Power of two, pointers wrap
   localparam int RX_PW    = $clog2(RX_DEPTH);   // Pointer bits
   localparam int RX_CW    = $clog2(RX_DEPTH + 1); // Fill count bits

   typedef enum logic [1:0] {
      SL_RAM,
      SL_NA,
      SL_ROM,
      SL_NONE
   } slave_e;

endpackage

/* rtl/tile_ram.sv */
module tile_ram (
   input  logic              clk,
   input  logic              reset_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   logic [tile_pkg::BUS_DW-1:0] mem [tile_pkg::MEM_SIZE / tile_pkg::BUS_SW];
   logic [tile_pkg::MEM_AW-3:0] idx;             // Word index, wraps over RAM size
   logic                        acc;             // Request taken this cycle
   logic                        ack_q;
   logic [tile_pkg::BUS_DW-1:0] dat_q;           // Registered read data

   assign idx = req_i.adr[tile_pkg::MEM_AW-1:2];
   assign acc = req_i.cyc & req_i.stb & ~ack_q;  // No new request in ack cycle

   always_ff @(posedge clk) begin
      if (acc & req_i.we) begin
         for (int b = 0; b < tile_pkg::BUS_SW; b++) begin
            if (req_i.sel[b]) mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8]; // Byte lane
         end
      end
      if (acc) dat_q <= mem[idx];                // Old word on a write, unused
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc;                           // One pulse per request
      end
   end

   assign rsp_o = '{dat: dat_q, ack: ack_q, err: 1'b0};

endmodule

/* sim/compute_tile_properties.sv */
module compute_tile_properties (
   input logic                       clk,
   input logic                       reset_i,
   input tile_pkg::wb_req_t          req_i,      // Core side request
   input tile_pkg::wb_rsp_t          rsp_i,      // Core side response
   input tile_pkg::flit_t            out_flit_i,
   input logic                       out_valid_i,
   input logic                       out_ready_i,
   input logic                       in_ready_i,
   input logic [tile_pkg::RX_CW-1:0] rx_count_i  // Adapter FIFO fill level
);

   a_ack_err_excl: assert property (@(posedge clk) disable iff (reset_i)
      !(rsp_i.ack && rsp_i.err))
      else $error("ack and err asserted in the same cycle");

   // Every response answers a strobe seen one edge earlier
   a_rsp_after_req: assert property (@(posedge clk) disable iff (reset_i)
      (rsp_i.ack || rsp_i.err) |-> $past(req_i.cyc && req_i.stb))
      else $error("bus response without a preceding request");

   a_out_stable: assert property (@(posedge clk) disable iff (reset_i)
      (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_flit_i)))
      else $error("outgoing flit changed or dropped while stalled");

   a_in_ready: assert property (@(posedge clk) disable iff (reset_i)
      (in_ready_i == 1'b0) == (rx_count_i == tile_pkg::RX_CW'(tile_pkg::RX_DEPTH)))
      else $error("receive ready does not match FIFO full state");

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen #(
   parameter int period = 8                      // Clock period in time units
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(period / 2) clk_o = ~clk_o;      // Free running, 50 percent duty
   end

endmodule

/* sim/tb_compute_tile.sv */
module tb_compute_tile #(
   parameter int bus_timeout = 40,               // Cycles before a bus wait gives up
   parameter int noc_timeout = 40,
   parameter int hold_cycles = 12                // Back-pressure observation window
);

   logic              clk;
   logic              reset_i;
   tile_pkg::wb_req_t core_req;
   tile_pkg::wb_rsp_t core_rsp;
   tile_pkg::flit_t   noc_in_flit;
   logic              noc_in_valid;
   logic              noc_in_ready;
   tile_pkg::flit_t   noc_out_flit;
   logic              noc_out_valid;
   logic              noc_out_ready;
   logic              irq;
   int                n_mismatch;
   int                n_fail;
   logic [31:0]       lfsr_q;
   tile_pkg::flit_t   out_q [$];                 // Flits that left the tile
   int                in_taken;                  // Flits taken on NoC input
   int                taken_mark;

   tb_clock_gen #(.period(8)) u_clk (.clk_o(clk));

   compute_tile #(.tile_id(3)) DUT (
      .clk (clk), .reset_i (reset_i), .core_req_i (core_req), .core_rsp_o (core_rsp),
      .noc_in_flit_i (noc_in_flit), .noc_in_valid_i (noc_in_valid),
      .noc_in_ready_o (noc_in_ready), .noc_out_flit_o (noc_out_flit),
      .noc_out_valid_o (noc_out_valid), .noc_out_ready_i (noc_out_ready), .irq_o (irq)
   );

   bind compute_tile compute_tile_properties u_props (
      .clk (clk), .reset_i (reset_i), .req_i (core_req_i), .rsp_i (core_rsp_o),
      .out_flit_i (noc_out_flit_o), .out_valid_i (noc_out_valid_o),
      .out_ready_i (noc_out_ready_i), .in_ready_i (noc_in_ready_o),
      .rx_count_i (u_na.rx_count_q)
   );

   always @(posedge clk) begin
      if (!reset_i && noc_out_valid && noc_out_ready) out_q.push_back(noc_out_flit); // Handshake
      if (!reset_i && noc_in_valid && noc_in_ready) in_taken++;
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         n_mismatch++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      check_val(name, 32'(got), 32'(exp));
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond === 1'b1) else begin
         $display("error at %0t: %s", $time, what);
         n_fail++;
      end
   endtask

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);             // One step per bit
         v = {v[30:0], lfsr_q[31]};
      end
   endtask

   task automatic bus_start(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we);
      @(negedge clk);
      core_req.adr = adr;
      core_req.dat = dat;
      core_req.sel = sel;
      core_req.we  = we;
      core_req.cyc = 1'b1;
      core_req.stb = 1'b1;                       // Held until ack or err
   endtask

   task automatic bus_wait(output logic [31:0] rdat, output logic ack, output logic err);
      int cnt;
      cnt = 0;
      do begin
         @(negedge clk);
         cnt++;
      end while (!(core_rsp.ack || core_rsp.err) && cnt < bus_timeout);
      rdat = core_rsp.dat;
      ack  = core_rsp.ack;
      err  = core_rsp.err;
      check_true(ack || err, "bus access got neither ack nor err before the timeout");
      core_req.cyc = 1'b0;
      core_req.stb = 1'b0;
   endtask

   task automatic bus_access(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, input logic we,
                             input logic exp_err, input logic [31:0] exp_dat);
      logic [31:0] rdat;
      logic        ack;
      logic        err;
      bus_start(adr, dat, sel, we);
      bus_wait(rdat, ack, err);
      check_bit("core_rsp.ack", ack, ~exp_err);
      check_bit("core_rsp.err", err, exp_err);
      if (!we && !exp_err) check_val("core_rsp.dat", rdat, exp_dat); // Reads only
   endtask

   task automatic wait_out_flits(input int n);
      int cnt;
      cnt = 0;
      while (out_q.size() < n && cnt < noc_timeout) begin
         @(negedge clk);
         cnt++;
      end
      check_true(out_q.size() >= n, "expected flits did not leave the tile");
   endtask

   task automatic expect_flit(input tile_pkg::flit_type_e ftype, input logic [31:0] data);
      tile_pkg::flit_t f;
      if (out_q.size() == 0) begin
         check_true(1'b0, "no outgoing flit left to compare");
      end else begin
         f = out_q.pop_front();
         check_val("noc_out_flit.ftype", 32'(f.ftype), 32'(ftype));
         check_val("noc_out_flit.data", f.data.raw, data);
      end
   endtask

   task automatic offer_flit(input tile_pkg::flit_t f);
      @(negedge clk);
      noc_in_flit  = f;
      noc_in_valid = 1'b1;
      taken_mark   = in_taken;
   endtask

   task automatic wait_flit_taken();
      int cnt;
      cnt = 0;
      while (in_taken == taken_mark && cnt < noc_timeout) begin
         @(negedge clk);
         cnt++;
      end
      check_true(in_taken != taken_mark, "offered flit was never accepted");
      noc_in_valid = 1'b0;                       // Dropped before the next edge
   endtask

   task automatic test_reset_state();
      @(negedge clk);
      check_bit("core_rsp.ack", core_rsp.ack, 1'b0);
      check_bit("core_rsp.err", core_rsp.err, 1'b0);
      check_bit("noc_out_valid", noc_out_valid, 1'b0);
      check_bit("irq", irq, 1'b0);
      check_bit("noc_in_ready", noc_in_ready, 1'b1);
   endtask

   task automatic test_ram();
      logic [31:0] model [8];                    // Expected RAM words
      logic [31:0] w;
      logic [31:0] sel;
      for (int i = 0; i < 8; i++) begin
         rand_bits(32, w);
         model[i] = w;
         bus_access(tile_pkg::RAM_BASE + 32'(i * 504), w, 4'hF, 1'b1, 1'b0, '0);
      end
      for (int i = 0; i < 8; i++) begin
         rand_bits(32, w);
         rand_bits(4, sel);                      // Mostly partial lanes
         bus_access(tile_pkg::RAM_BASE + 32'(i * 504), w, sel[3:0], 1'b1, 1'b0, '0);
         for (int b = 0; b < 4; b++) begin
            if (sel[b]) model[i][8*b +: 8] = w[8*b +: 8];
         end
      end
      for (int i = 0; i < 8; i++) begin
         bus_access(tile_pkg::RAM_BASE + 32'(i * 504), '0, 4'hF, 1'b0, 1'b0, model[i]);
      end
   endtask

   task automatic test_bootrom();
      logic [31:0] w;
      for (int i = 0; i < tile_pkg::BOOTROM_WORDS; i++) begin
         bus_access(tile_pkg::ROM_BASE + 32'(4 * i), '0, 4'hF, 1'b0, 1'b0,
                    tile_pkg::BOOTROM_INIT[i]);
      end
      bus_access(tile_pkg::ROM_BASE + 32'(4 * tile_pkg::BOOTROM_WORDS), '0, 4'hF,
                 1'b0, 1'b0, '0);                // Past the table
      rand_bits(32, w);
      bus_access(tile_pkg::ROM_BASE, w, 4'hF, 1'b1, 1'b1, '0);
      bus_access(tile_pkg::ROM_BASE, '0, 4'hF, 1'b0, 1'b0, tile_pkg::BOOTROM_INIT[0]);
   endtask

   task automatic test_unmapped();
      bus_access(32'h8000_0000, '0, 4'hF, 1'b0, 1'b1, '0);
      bus_access(32'h8000_0010, 32'h1234_5678, 4'hF, 1'b1, 1'b1, '0);
   endtask

   task automatic test_transmit();
      logic [31:0]          w [3];
      tile_pkg::flit_data_u hdr;
      logic [31:0]          rdat;
      logic                 ack;
      logic                 err;
      int                   cnt;
      out_q.delete();
      for (int i = 0; i < 3; i++) begin
         rand_bits(32, w[i]);
      end
      bus_access(tile_pkg::NA_BASE + tile_pkg::NA_TX_HEADER, w[0], 4'hF, 1'b1, 1'b0, '0);
      bus_access(tile_pkg::NA_BASE + tile_pkg::NA_TX_PAYLOAD, w[1], 4'hF, 1'b1, 1'b0, '0);
      bus_access(tile_pkg::NA_BASE + tile_pkg::NA_TX_LAST, w[2], 4'hF, 1'b1, 1'b0, '0);
      wait_out_flits(3);
      hdr.raw     = w[0];
      hdr.hdr.src = 5'd3;                        // Own tile id replaces src
      expect_flit(tile_pkg::HEADER, hdr.raw);
      expect_flit(tile_pkg::PAYLOAD, w[1]);
      expect_flit(tile_pkg::LAST, w[2]);
      @(negedge clk);
      noc_out_ready = 1'b0;                      // Router stalls
      rand_bits(32, w[0]);
      rand_bits(32, w[1]);
      bus_access(tile_pkg::NA_BASE + tile_pkg::NA_TX_PAYLOAD, w[0], 4'hF, 1'b1, 1'b0, '0);
      cnt = 0;
      while (!noc_out_valid && cnt < noc_timeout) begin
         @(negedge clk);
         cnt++;
      end
      check_true(noc_out_valid, "transmit flit never became valid");
      bus_start(tile_pkg::NA_BASE + tile_pkg::NA_TX_LAST, w[1], 4'hF, 1'b1);
      for (int k = 0; k < hold_cycles; k++) begin
         @(negedge clk);
         check_true(!core_rsp.ack && !core_rsp.err, "transmit write ended while stalled");
         check_bit("noc_out_valid", noc_out_valid, 1'b1);
         check_val("noc_out_flit.data", noc_out_flit.data.raw, w[0]);
         check_val("noc_out_flit.ftype", 32'(noc_out_flit.ftype), 32'(tile_pkg::PAYLOAD));
      end
      noc_out_ready = 1'b1;
      bus_wait(rdat, ack, err);
      check_bit("core_rsp.ack", ack, 1'b1);
      wait_out_flits(2);
      expect_flit(tile_pkg::PAYLOAD, w[0]);
      expect_flit(tile_pkg::LAST, w[1]);
   endtask

   task automatic test_receive();
      tile_pkg::flit_t f [5];
      logic [31:0]     w;
      logic [31:0]     status;
      for (int i = 0; i < 5; i++) begin
         rand_bits(32, w);
         f[i].data.raw = w;
         f[i].ftype    = (i == 0) ? tile_pkg::HEADER :
                         ((i == 4) ? tile_pkg::LAST : tile_pkg::PAYLOAD);
      end
      for (int i = 0; i < 4; i++) begin
         offer_flit(f[i]);
         wait_flit_taken();
      end
      @(negedge clk);
      check_bit("noc_in_ready", noc_in_ready, 1'b0);
      check_bit("irq", irq, 1'b1);
      status        = '0;
      status[2:0]   = 3'd4;                      // FIFO full
      status[17:16] = f[0].ftype;                // Head flit type
      bus_access(tile_pkg::NA_BASE + tile_pkg::NA_RX_STATUS, '0, 4'hF, 1'b0, 1'b0, status);
      offer_flit(f[4]);
      for (int k = 0; k < 3; k++) begin
         @(negedge clk);
         check_true(in_taken == taken_mark, "flit accepted into a full receive FIFO");
      end
      bus_access(tile_pkg::NA_BASE + tile_pkg::NA_RX_DATA, '0, 4'hF, 1'b0, 1'b0,
                 f[0].data.raw);
      wait_flit_taken();                         // Slot freed by the pop
      for (int i = 1; i < 5; i++) begin
         bus_access(tile_pkg::NA_BASE + tile_pkg::NA_RX_DATA, '0, 4'hF, 1'b0, 1'b0,
                    f[i].data.raw);
      end
      check_bit("irq", irq, 1'b0);
   endtask

   initial begin
      core_req      = '0;
      noc_in_flit   = '0;
      noc_in_valid  = 1'b0;
      noc_out_ready = 1'b1;
      reset_i       = 1'b1;
      n_mismatch    = 0;
      n_fail        = 0;
      in_taken      = 0;
      taken_mark    = 0;
      lfsr_q        = 32'hbab4;
      repeat (8) @(negedge clk);
      reset_i = 1'b0;
      test_reset_state();
      test_ram();
      test_bootrom();
      test_unmapped();
      test_transmit();
      test_receive();
      repeat (4) @(negedge clk);
      $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_fail);
      if (n_mismatch == 0 && n_fail == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* verilog.f */
rtl/tile_pkg.sv
rtl/tile_bus_decode.sv
rtl/tile_ram.sv
rtl/tile_bootrom.sv
rtl/noc_adapter.sv
rtl/compute_tile.sv
sim/tb_clock_gen.sv
sim/compute_tile_properties.sv
sim/tb_compute_tile.sv
